/* hdl/imuldiv_msg_pkg.sv */
// request and response message layout of the integer mul/div unit
// function code 3 is reserved and must never be presented
`default_nettype none

package imuldiv_msg_pkg;

  // --------------------------------------------------------------------------
  // message widths
  // --------------------------------------------------------------------------

  // each request operand
  localparam int operand_width = 32;

  // response carries the full product, or remainder over quotient
  localparam int result_width = 2 * operand_width;

  // function code field of the request
  localparam int func_width = 2;

  // --------------------------------------------------------------------------
  // function codes
  // --------------------------------------------------------------------------

  // signed multiply, full 64-bit product
  localparam logic [func_width-1:0] func_mul = 2'd0;
  // signed divide, truncates toward zero
  localparam logic [func_width-1:0] func_div = 2'd1;
  // unsigned divide
  localparam logic [func_width-1:0] func_divu = 2'd2;

endpackage

`default_nettype wire

/* hdl/imuldiv_ctrl_pkg.sv */
// encodings for the iterative sequencer shared by both datapaths
// count_width must hold iter_count - 1
`default_nettype none

package imuldiv_ctrl_pkg;

  // --------------------------------------------------------------------------
  // sequencer states
  // --------------------------------------------------------------------------

  // idle accepts, calc iterates, done holds the response
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } ctrl_state_t;

  // one iteration per operand bit
  localparam int iter_count = 32;

  // iteration counter width
  localparam int count_width = 6;

endpackage

`default_nettype wire

/* hdl/iter_ctrl.sv */
// valid/ready sequencer for one iterative datapath
// latency from accept to resp_val is iter_count + 1 cycles, no early exit
`timescale 1ns/1ps
`default_nettype none

module iter_ctrl
  import imuldiv_ctrl_pkg::*;
(
  input  wire  clk,
  input  wire  reset,
  input  wire  req_val,
  output logic req_rdy,
  output logic resp_val,
  input  wire  resp_rdy,
  output logic load_en,
  output logic step_en
);

  // last counter value before leaving calc
  localparam logic [count_width-1:0] last_count = count_width'(iter_count - 1);

  ctrl_state_t            state;
  logic [count_width-1:0] count;

  // --------------------------------------------------------------------------
  // state and iteration counter
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          // accepting edge, counter restarts for the new operation
          if (load_en) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          if (count == last_count) begin
            state <= st_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        st_done: begin
          // hold the result until the consumer takes it
          if (resp_val && resp_rdy) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // outputs, decoded from state
  // --------------------------------------------------------------------------

  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);
  // single pulse on the handshake edge
  assign load_en  = req_val && req_rdy;
  // one datapath iteration per calc cycle
  assign step_en  = (state == st_calc);

endmodule

`default_nettype wire

/* hdl/int_mul_iterative_dpath.sv */
// signed shift-and-add multiplier datapath, one product bit per step
// result is only meaningful after iter_count steps following a load
`timescale 1ns/1ps
`default_nettype none

module int_mul_iterative_dpath
  import imuldiv_msg_pkg::*;
(
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      load_en,
  input  wire                      step_en,
  input  wire  [operand_width-1:0] req_a,
  input  wire  [operand_width-1:0] req_b,
  output logic [result_width-1:0]  result
);

  // operand sign bits as captured at load
  logic sign_a;
  logic sign_b;

  // unsigned magnitudes of the incoming operands
  logic [operand_width-1:0] a_mag;
  logic [operand_width-1:0] b_mag;

  // multiplicand widens as it shifts left, multiplier drains to the right
  logic [result_width-1:0]  mcand;
  logic [operand_width-1:0] mplr;

  // running sum of partial products
  logic [result_width-1:0] acc;
  logic [result_width-1:0] acc_next;

  // --------------------------------------------------------------------------
  // operand conditioning
  // --------------------------------------------------------------------------

  // two's complement magnitude, most negative value maps to 2**31
  assign a_mag = req_a[operand_width-1] ? (~req_a) + 1'b1 : req_a;
  assign b_mag = req_b[operand_width-1] ? (~req_b) + 1'b1 : req_b;

  // add the multiplicand only when the current multiplier bit is set
  assign acc_next = mplr[0] ? acc + mcand : acc;

  // --------------------------------------------------------------------------
  // control-visible state
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      sign_a <= 1'b0;
      sign_b <= 1'b0;
      acc    <= '0;
    end else if (load_en) begin
      sign_a <= req_a[operand_width-1];
      sign_b <= req_b[operand_width-1];
      acc    <= '0;
    end else if (step_en) begin
      acc <= acc_next;
    end
  end

  // operand shifters
  always_ff @(posedge clk) begin
    if (load_en) begin
      mcand <= {{operand_width{1'b0}}, a_mag};
      mplr  <= b_mag;
    end else if (step_en) begin
      mcand <= mcand << 1;
      mplr  <= mplr >> 1;
    end
  end

  // --------------------------------------------------------------------------
  // sign fix
  // --------------------------------------------------------------------------

  // product is negative when exactly one operand was negative
  assign result = (sign_a ^ sign_b) ? (~acc) + 1'b1 : acc;

endmodule

`default_nettype wire

/* hdl/int_div_iterative_dpath.sv */
// restoring divider datapath, one quotient bit per step, msb first
// zero divisor gives an unspecified result
// is_signed is sampled only on load_en
`timescale 1ns/1ps
`default_nettype none

module int_div_iterative_dpath
  import imuldiv_msg_pkg::*;
(
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      load_en,
  input  wire                      step_en,
  input  wire                      is_signed,
  input  wire  [operand_width-1:0] req_a,
  input  wire  [operand_width-1:0] req_b,
  output logic [result_width-1:0]  result
);

  // operation kind and operand signs of the operation in flight
  logic signed_op;
  logic sign_a;
  logic sign_b;

  // dividend/divisor as loaded, magnitudes when signed
  logic [operand_width-1:0] a_mag;
  logic [operand_width-1:0] b_mag;

  // dividend bits leave at the top while quotient bits enter at the bottom
  logic [operand_width-1:0] dq;
  logic [operand_width-1:0] divisor;
  logic [operand_width-1:0] rem;

  // one restoring step
  logic [operand_width:0]   rem_shift;
  logic [operand_width+1:0] trial;
  logic                     q_bit;
  logic [operand_width-1:0] rem_next;

  // sign-corrected halves of the response
  logic [operand_width-1:0] rem_out;
  logic [operand_width-1:0] quo_out;

  // --------------------------------------------------------------------------
  // operand conditioning
  // --------------------------------------------------------------------------

  // raw operands pass through for unsigned division
  assign a_mag = (is_signed && req_a[operand_width-1]) ? (~req_a) + 1'b1 : req_a;
  assign b_mag = (is_signed && req_b[operand_width-1]) ? (~req_b) + 1'b1 : req_b;

  // --------------------------------------------------------------------------
  // restoring step
  // --------------------------------------------------------------------------

  // bring down the next dividend bit
  assign rem_shift = {rem, dq[operand_width-1]};
  // extra top bit flags a negative difference
  assign trial     = {1'b0, rem_shift} - {2'b00, divisor};
  assign q_bit     = ~trial[operand_width+1];
  // remainder stays below the divisor, so the low bits always suffice
  assign rem_next  = q_bit ? trial[operand_width-1:0] : rem_shift[operand_width-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      signed_op <= 1'b0;
      sign_a    <= 1'b0;
      sign_b    <= 1'b0;
      rem       <= '0;
    end else if (load_en) begin
      signed_op <= is_signed;
      sign_a    <= req_a[operand_width-1];
      sign_b    <= req_b[operand_width-1];
      rem       <= '0;
    end else if (step_en) begin
      rem <= rem_next;
    end
  end

  // dividend/quotient shifter and divisor hold
  always_ff @(posedge clk) begin
    if (load_en) begin
      dq      <= a_mag;
      divisor <= b_mag;
    end else if (step_en) begin
      dq <= {dq[operand_width-2:0], q_bit};
    end
  end

  // --------------------------------------------------------------------------
  // sign fix
  // --------------------------------------------------------------------------

  // remainder follows the dividend sign
  assign rem_out = (signed_op && sign_a) ? (~rem) + 1'b1 : rem;
  // quotient negative when signs differ, which truncates toward zero
  assign quo_out = (signed_op && (sign_a ^ sign_b)) ? (~dq) + 1'b1 : dq;

  assign result = {rem_out, quo_out};

endmodule

`default_nettype wire

/* hdl/int_muldiv_iterative.sv */
// iterative 32-bit mul/div unit, one operation in flight at a time
// code 3 is never accepted, req_rdy stays high but nothing starts
// response holds remainder over quotient for divide
`timescale 1ns/1ps
`default_nettype none

module int_muldiv_iterative
  import imuldiv_msg_pkg::*;
(
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      req_val,
  output logic                     req_rdy,
  input  wire  [func_width-1:0]    req_func,
  input  wire  [operand_width-1:0] req_a,
  input  wire  [operand_width-1:0] req_b,
  output logic                     resp_val,
  input  wire                      resp_rdy,
  output logic [result_width-1:0]  resp_result
);

  // per-unit handshakes
  logic mul_req_val;
  logic mul_req_rdy;
  logic mul_resp_val;
  logic div_req_val;
  logic div_req_rdy;
  logic div_resp_val;

  // sequencer to datapath strobes
  logic mul_load_en;
  logic mul_step_en;
  logic div_load_en;
  logic div_step_en;

  logic                    div_signed;
  logic [result_width-1:0] mul_result;
  logic [result_width-1:0] div_result;

  // --------------------------------------------------------------------------
  // request dispatch
  // --------------------------------------------------------------------------

  // accept only when both units are idle
  assign req_rdy = mul_req_rdy && div_req_rdy;

  // qualified by req_rdy so an idle unit cannot start while the other is busy
  assign mul_req_val = req_val && req_rdy && (req_func == func_mul);
  assign div_req_val = req_val && req_rdy &&
                       ((req_func == func_div) || (req_func == func_divu));
  assign div_signed  = (req_func == func_div);

  // --------------------------------------------------------------------------
  // multiplier
  // --------------------------------------------------------------------------

  iter_ctrl mul_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp_val (mul_resp_val),
    .resp_rdy (resp_rdy),
    .load_en  (mul_load_en),
    .step_en  (mul_step_en)
  );

  int_mul_iterative_dpath mul_dpath (
    .clk     (clk),
    .reset   (reset),
    .load_en (mul_load_en),
    .step_en (mul_step_en),
    .req_a   (req_a),
    .req_b   (req_b),
    .result  (mul_result)
  );

  // --------------------------------------------------------------------------
  // divider
  // --------------------------------------------------------------------------

  iter_ctrl div_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp_val (div_resp_val),
    .resp_rdy (resp_rdy),
    .load_en  (div_load_en),
    .step_en  (div_step_en)
  );

  int_div_iterative_dpath div_dpath (
    .clk       (clk),
    .reset     (reset),
    .load_en   (div_load_en),
    .step_en   (div_step_en),
    .is_signed (div_signed),
    .req_a     (req_a),
    .req_b     (req_b),
    .result    (div_result)
  );

  // --------------------------------------------------------------------------
  // response merge
  // --------------------------------------------------------------------------

  // at most one unit sits in done at a time
  assign resp_val    = mul_resp_val || div_resp_val;
  assign resp_result = mul_resp_val ? mul_result : div_result;

endmodule

`default_nettype wire

/* verification/tb_int_muldiv_iterative.sv */
// directed testbench for the iterative mul/div unit
// divide tests never present a zero divisor and code 3 is never driven
`timescale 1ns/1ps
`default_nettype none

module tb_int_muldiv_iterative
  import imuldiv_msg_pkg::*;
;

  localparam int clk_period   = 10;
  // requests issued by all tests together set the watchdog limit
  localparam int num_requests = 75;
  localparam int timeout_cycles = num_requests * 40 + 300;

  logic                     clk;
  logic                     reset;
  logic                     req_val;
  logic                     req_rdy;
  logic [func_width-1:0]    req_func;
  logic [operand_width-1:0] req_a;
  logic [operand_width-1:0] req_b;
  logic                     resp_val;
  logic                     resp_rdy;
  logic [result_width-1:0]  resp_result;

  int     error_count = 0;
  int     check_count = 0;
  integer seed = 32'h3722_2c66;
  // resp_rdy stays high across a whole sequence of requests
  logic   hold_rdy;

  int_muldiv_iterative uut (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_func    (req_func),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // reference model and checking
  // --------------------------------------------------------------------------

  // full signed product, or remainder over quotient with truncation toward zero
  function automatic logic [63:0] expected_result(input logic [1:0] func,
                                                  input logic [31:0] a,
                                                  input logic [31:0] b);
    logic signed [63:0] prod;
    logic [31:0]        ua;
    logic [31:0]        ub;
    logic [31:0]        q;
    logic [31:0]        r;
    case (func)
      func_mul: begin
        prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        return prod;
      end
      func_divu: begin
        q = a / b;
        r = a % b;
        return {r, q};
      end
      func_div: begin
        // divide magnitudes, then apply the signs
        ua = a[31] ? 32'd0 - a : a;
        ub = b[31] ? 32'd0 - b : b;
        q  = ua / ub;
        r  = ua % ub;
        if (a[31] ^ b[31]) q = 32'd0 - q;
        // remainder follows the dividend
        if (a[31]) r = 32'd0 - r;
        return {r, q};
      end
      default: return 64'd0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
               $time, name, expected, actual);
    end
  endtask

  // random pair with the divisor forced nonzero
  task automatic random_operands(output logic [31:0] a, output logic [31:0] b);
    a = $random(seed);
    b = $random(seed);
    if (b == 32'd0) b = 32'd1;
  endtask

  // --------------------------------------------------------------------------
  // one request through the unit
  // --------------------------------------------------------------------------

  // stall counts back-pressure cycles after resp_val rises
  task automatic run_op(input logic [1:0] func, input logic [31:0] a,
                        input logic [31:0] b, input int stall);
    int          latency;
    logic [63:0] expected;
    logic [63:0] held;
    expected = expected_result(func, a, b);
    @(posedge clk);
    req_val  <= 1'b1;
    req_func <= func;
    req_a    <= a;
    req_b    <= b;
    @(negedge clk);
    while (!req_rdy) @(negedge clk);
    // accepting edge
    @(posedge clk);
    req_val <= 1'b0;
    // scramble operands so only the captured copy matters
    req_a   <= ~a;
    req_b   <= ~b;
    latency = 1;
    @(negedge clk);
    while (!resp_val) begin
      @(negedge clk);
      latency++;
    end
    check_value("latency", 64'd33, 64'(latency));
    check_value("resp_result", expected, resp_result);
    held = resp_result;
    if (!hold_rdy) begin
      repeat (stall) begin
        @(negedge clk);
        check_value("resp_val", 64'd1, 64'(resp_val));
        check_value("resp_result", held, resp_result);
        check_value("req_rdy", 64'd0, 64'(req_rdy));
      end
      @(posedge clk);
      resp_rdy <= 1'b1;
      // still busy in the cycle of the handshake
      @(negedge clk);
      check_value("req_rdy", 64'd0, 64'(req_rdy));
      // handshake edge
      @(posedge clk);
      resp_rdy <= 1'b0;
    end else begin
      @(posedge clk);
    end
    // unit must be idle again in the cycle after the handshake
    @(negedge clk);
    check_value("resp_val", 64'd0, 64'(resp_val));
    check_value("req_rdy", 64'd1, 64'(req_rdy));
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------

  task automatic test_reset_state();
    @(negedge clk);
    check_value("req_rdy", 64'd1, 64'(req_rdy));
    check_value("resp_val", 64'd0, 64'(resp_val));
  endtask

  task automatic test_mul();
    logic [31:0] a;
    logic [31:0] b;
    run_op(func_mul, 32'd0, 32'd5, 0);
    run_op(func_mul, 32'd1, 32'hffff_fff9, 0);
    run_op(func_mul, 32'hffff_ffff, 32'hffff_ffff, 0);
    run_op(func_mul, 32'h8000_0000, 32'h8000_0000, 0);
    run_op(func_mul, 32'h8000_0000, 32'd1, 0);
    run_op(func_mul, 32'h7fff_ffff, 32'h8000_0000, 0);
    run_op(func_mul, 32'hffff_fffd, 32'd12345, 0);
    run_op(func_mul, 32'd123, 32'hffff_fe38, 0);
    repeat (16) begin
      random_operands(a, b);
      run_op(func_mul, a, b, 0);
    end
  endtask

  task automatic test_div();
    logic [31:0] a;
    logic [31:0] b;
    // all four sign combinations of 7 / 2
    run_op(func_div, 32'd7, 32'd2, 0);
    run_op(func_div, 32'hffff_fff9, 32'd2, 0);
    run_op(func_div, 32'd7, 32'hffff_fffe, 0);
    run_op(func_div, 32'hffff_fff9, 32'hffff_fffe, 0);
    run_op(func_div, 32'h8000_0000, 32'hffff_ffff, 0);
    run_op(func_div, 32'h8000_0000, 32'd7, 0);
    run_op(func_div, 32'd5, 32'hffff_fff7, 0);
    run_op(func_div, 32'hffff_ff9c, 32'd100, 0);
    repeat (16) begin
      random_operands(a, b);
      run_op(func_div, a, b, 0);
    end
  endtask

  // top bits set so signed and unsigned readings differ
  task automatic test_divu();
    logic [31:0] a;
    logic [31:0] b;
    run_op(func_divu, 32'hffff_ffff, 32'd3, 0);
    run_op(func_divu, 32'h8000_0000, 32'd7, 0);
    run_op(func_divu, 32'hfedc_ba98, 32'h8000_0001, 0);
    run_op(func_divu, 32'hffff_fff9, 32'd2, 0);
    run_op(func_divu, 32'd100, 32'hffff_fff0, 0);
    run_op(func_divu, 32'h8765_4321, 32'h0000_1234, 0);
    repeat (8) begin
      random_operands(a, b);
      run_op(func_divu, a | 32'h8000_0000, b, 0);
    end
  endtask

  task automatic test_back_pressure();
    logic [31:0] a;
    logic [31:0] b;
    int          stall;
    for (int i = 0; i < 4; i++) begin
      random_operands(a, b);
      stall = ($random(seed) & 15) + 1;
      case (i % 3)
        0: run_op(func_mul, a, b, stall);
        1: run_op(func_div, a, b, stall);
        default: run_op(func_divu, a, b, stall);
      endcase
    end
  endtask

  // alternate units with resp_rdy held high, so responses drain at once
  task automatic test_switching();
    logic [31:0] a;
    logic [31:0] b;
    hold_rdy = 1'b1;
    @(posedge clk);
    resp_rdy <= 1'b1;
    repeat (3) begin
      random_operands(a, b);
      run_op(func_mul, a, b, 0);
      random_operands(a, b);
      run_op(func_div, a, b, 0);
      random_operands(a, b);
      run_op(func_divu, a, b, 0);
    end
    @(posedge clk);
    resp_rdy <= 1'b0;
    hold_rdy = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // sequence and watchdog
  // --------------------------------------------------------------------------

  initial begin
    reset    <= 1'b1;
    req_val  <= 1'b0;
    req_func <= func_mul;
    req_a    <= '0;
    req_b    <= '0;
    resp_rdy <= 1'b0;
    hold_rdy = 1'b0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    test_reset_state();
    test_mul();
    test_div();
    test_divu();
    test_back_pressure();
    test_switching();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(timeout_cycles * clk_period);
    $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
hdl/imuldiv_msg_pkg.sv
hdl/imuldiv_ctrl_pkg.sv
hdl/iter_ctrl.sv
hdl/int_mul_iterative_dpath.sv
hdl/int_div_iterative_dpath.sv
hdl/int_muldiv_iterative.sv
verification/tb_int_muldiv_iterative.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run the testbench, decide on the pass line in sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --timescale 1ns/1ps --top-module tb_int_muldiv_iterative \
  -f all.f -o sim_tb > build.log 2>&1 &&
  ./obj_dir/sim_tb > sim.log 2>&1 ||
  { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "^Verification passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
